/* list.f */
rtl/noc_lookup_pkg.sv
rtl/route_table_apb.sv
rtl/packet_route_fsm.sv
rtl/lookup_slice.sv
rtl/port_flit_counters.sv
rtl/router_lookup.sv
tests/tb_router_lookup.sv

/* rtl/lookup_slice.sv */
////////////////////
// Two-register skid stage, one-hot valid out, per-output ready
////////////////////
module lookup_slice (
  input  logic                               clk,
  input  logic                               rst,
  input  noc_lookup_pkg::flit_t              in_flit,
  input  logic [noc_lookup_pkg::OUTPUTS-1:0] in_valid,
  output logic                               in_ready,
  output noc_lookup_pkg::flit_t              out_flit,
  output logic [noc_lookup_pkg::OUTPUTS-1:0] out_valid,
  input  logic [noc_lookup_pkg::OUTPUTS-1:0] out_ready
);

  // Skid register, holds a flit that arrived while the output stalled
  noc_lookup_pkg::flit_t              skid_flit;
  logic [noc_lookup_pkg::OUTPUTS-1:0] skid_valid;
  // Skid register full, input blocked
  logic                               pressure;
  logic                               out_xfer;
  logic                               out_busy;
  logic                               in_any;

  // Only the port that is presented can take the flit
  assign out_xfer = |(out_valid & out_ready);
  assign out_busy = |out_valid;
  assign in_any   = |in_valid;

  // Input stalls one cycle after the output does
  assign in_ready = ~pressure;

  ////////////////////
  // Control

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= '0;
      pressure  <= 1'b0;
    end else if (!pressure) begin
      if (!out_busy || out_xfer) begin
        // Output free or leaving now, new flit goes straight out
        out_valid <= in_valid;
      end else if (in_any) begin
        // Output stalled, park the arriving flit
        pressure <= 1'b1;
      end
    end else if (out_xfer) begin
      // Presented flit gone, skid flit moves up
      out_valid <= skid_valid;
      pressure  <= 1'b0;
    end
  end

  ////////////////////
  // Payload

  always_ff @(posedge clk) begin
    if (!pressure) begin
      if (!out_busy || out_xfer) begin
        out_flit <= in_flit;
      end else if (in_any) begin
        skid_flit  <= in_flit;
        skid_valid <= in_valid;
      end
    end else if (out_xfer) begin
      out_flit <= skid_flit;
    end
  end

endmodule

/* rtl/noc_lookup_pkg.sv */
////////////////////
// Lookup stage widths, APB address map, port and framing enums
// Flit and APB request/response structs
////////////////////
package noc_lookup_pkg;

  ////////////////////
  // Widths

  // Flit payload
  localparam int FLIT_WIDTH     = 32;
  // Output ports of the mesh router
  localparam int OUTPUTS        = 5;
  // Destination field, 16 table entries
  localparam int DEST_WIDTH     = 4;
  // Destination sits in the top nibble of a header flit
  localparam int DEST_LSB       = 28;
  localparam int PORT_IDX_WIDTH = 3;
  // Statistics counters
  localparam int CNT_WIDTH      = 32;
  localparam int APB_ADDR_WIDTH = 8;
  localparam int APB_DATA_WIDTH = 32;

  ////////////////////
  // APB address map

  // Route entry d at ROUTE_BASE + 4*d
  localparam logic [APB_ADDR_WIDTH-1:0] ROUTE_BASE    = 8'h00;
  // Flit counter of output i at FLIT_CNT_BASE + 4*i
  localparam logic [APB_ADDR_WIDTH-1:0] FLIT_CNT_BASE = 8'h40;
  // Packet counter of output i at PKT_CNT_BASE + 4*i
  localparam logic [APB_ADDR_WIDTH-1:0] PKT_CNT_BASE  = 8'h60;

  ////////////////////
  // Enums

  typedef enum logic [PORT_IDX_WIDTH-1:0] {
    PORT_LOCAL = 3'd0,
    PORT_NORTH = 3'd1,
    PORT_EAST  = 3'd2,
    PORT_SOUTH = 3'd3,
    PORT_WEST  = 3'd4
  } out_port_e;

  // Packet framing
  typedef enum logic {
    ST_HEAD,  // waiting for a header flit
    ST_BODY   // inside a packet
  } route_state_e;

  ////////////////////
  // Structs

  typedef struct packed {
    logic                  last;
    logic [FLIT_WIDTH-1:0] data;
  } flit_t;

  typedef struct packed {
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
  } apb_rsp_t;

endpackage

/* rtl/packet_route_fsm.sv */
////////////////////
// Packet framing FSM, output port fixed at the header flit
////////////////////
module packet_route_fsm (
  input  logic                                  clk,
  input  logic                                  rst,
  input  noc_lookup_pkg::flit_t                 in_flit,
  input  logic                                  in_valid,
  output logic                                  in_ready,
  output logic [noc_lookup_pkg::DEST_WIDTH-1:0] lookup_dest,
  input  noc_lookup_pkg::out_port_e             lookup_port,
  output logic [noc_lookup_pkg::OUTPUTS-1:0]    slice_valid,
  input  logic                                  slice_ready
);

  noc_lookup_pkg::route_state_e            state_q;
  // Port vector of the packet in flight
  logic [noc_lookup_pkg::OUTPUTS-1:0]      body_valid_q;
  logic [noc_lookup_pkg::OUTPUTS-1:0]      head_valid;
  logic                                    accept;

  // Destination field of the current flit, only meaningful on a header
  assign lookup_dest =
    in_flit.data[noc_lookup_pkg::DEST_LSB +: noc_lookup_pkg::DEST_WIDTH];

  // One-hot vector of the looked-up port
  always_comb begin
    for (int i = 0; i < noc_lookup_pkg::OUTPUTS; i++) begin
      head_valid[i] = (lookup_port == noc_lookup_pkg::out_port_e'(i));
    end
  end

  // Slice back-pressure goes straight to the source
  assign in_ready = slice_ready;
  assign accept   = in_valid & slice_ready;

  ////////////////////
  // Valid steering

  always_comb begin
    slice_valid = '0;
    if (in_valid) begin
      if (state_q == noc_lookup_pkg::ST_HEAD) begin
        slice_valid = head_valid;
      end else begin
        slice_valid = body_valid_q;
      end
    end
  end

  ////////////////////
  // Framing state

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= noc_lookup_pkg::ST_HEAD;
    end else begin
      case (state_q)
        noc_lookup_pkg::ST_HEAD: begin
          // Single-flit packets stay in ST_HEAD
          if (accept && !in_flit.last) begin
            state_q <= noc_lookup_pkg::ST_BODY;
          end
        end
        noc_lookup_pkg::ST_BODY: begin
          if (accept && in_flit.last) begin
            state_q <= noc_lookup_pkg::ST_HEAD;
          end
        end
        default: state_q <= noc_lookup_pkg::ST_HEAD;
      endcase
    end
  end

  // Port is frozen at the header, later table writes do not move the packet
  always_ff @(posedge clk) begin
    if (state_q == noc_lookup_pkg::ST_HEAD && accept && !in_flit.last) begin
      body_valid_q <= head_valid;
    end
  end

endmodule

/* rtl/port_flit_counters.sv */
////////////////////
// Per-output counters of delivered flits and packets
////////////////////
module port_flit_counters (
  input  logic                               clk,
  input  logic                               rst,
  input  noc_lookup_pkg::flit_t              out_flit,
  input  logic [noc_lookup_pkg::OUTPUTS-1:0] out_valid,
  input  logic [noc_lookup_pkg::OUTPUTS-1:0] out_ready,
  output logic [noc_lookup_pkg::OUTPUTS-1:0][noc_lookup_pkg::CNT_WIDTH-1:0] flit_cnt,
  output logic [noc_lookup_pkg::OUTPUTS-1:0][noc_lookup_pkg::CNT_WIDTH-1:0] pkt_cnt
);

  // Transfer per output, valid and ready on the same bit
  logic [noc_lookup_pkg::OUTPUTS-1:0] xfer;

  assign xfer = out_valid & out_ready;

  ////////////////////
  // Counters

  // Both wrap at CNT_WIDTH
  always_ff @(posedge clk) begin
    if (rst) begin
      flit_cnt <= '0;
      pkt_cnt  <= '0;
    end else begin
      for (int i = 0; i < noc_lookup_pkg::OUTPUTS; i++) begin
        if (xfer[i]) begin
          flit_cnt[i] <= flit_cnt[i] + 1'b1;
          // A packet ends with its last flit
          if (out_flit.last) begin
            pkt_cnt[i] <= pkt_cnt[i] + 1'b1;
          end
        end
      end
    end
  end

endmodule

/* rtl/route_table_apb.sv */
////////////////////
// APB register block with the routing table and counter readout
////////////////////
module route_table_apb (
  input  logic                             clk,
  input  logic                             rst,
  input  noc_lookup_pkg::apb_req_t         apb_req,
  output noc_lookup_pkg::apb_rsp_t         apb_rsp,
  input  logic [noc_lookup_pkg::DEST_WIDTH-1:0] lookup_dest,
  output noc_lookup_pkg::out_port_e        lookup_port,
  input  logic [noc_lookup_pkg::OUTPUTS-1:0][noc_lookup_pkg::CNT_WIDTH-1:0] flit_cnt,
  input  logic [noc_lookup_pkg::OUTPUTS-1:0][noc_lookup_pkg::CNT_WIDTH-1:0] pkt_cnt
);

  // One port index per destination
  noc_lookup_pkg::out_port_e route_q [2**noc_lookup_pkg::DEST_WIDTH];

  logic                                      access;
  logic                                      aligned;
  logic [noc_lookup_pkg::APB_ADDR_WIDTH-1:0] route_off;
  logic [noc_lookup_pkg::APB_ADDR_WIDTH-1:0] flit_off;
  logic [noc_lookup_pkg::APB_ADDR_WIDTH-1:0] pkt_off;
  logic                                      route_hit;
  logic                                      flit_hit;
  logic                                      pkt_hit;
  logic [noc_lookup_pkg::DEST_WIDTH-1:0]     route_idx;
  logic [noc_lookup_pkg::PORT_IDX_WIDTH-1:0] flit_idx;
  logic [noc_lookup_pkg::PORT_IDX_WIDTH-1:0] pkt_idx;
  logic                                      wdata_ok;
  logic                                      route_we;
  logic [noc_lookup_pkg::APB_DATA_WIDTH-1:0] rd_data;

  ////////////////////
  // Address decode

  // Access phase, no wait states
  assign access  = apb_req.psel & apb_req.penable;
  // Word addresses only
  assign aligned = (apb_req.paddr[1:0] == 2'b00);

  // Offsets into each region, wrap makes addresses below a base miss
  assign route_off = apb_req.paddr - noc_lookup_pkg::ROUTE_BASE;
  assign flit_off  = apb_req.paddr - noc_lookup_pkg::FLIT_CNT_BASE;
  assign pkt_off   = apb_req.paddr - noc_lookup_pkg::PKT_CNT_BASE;

  assign route_hit = aligned &
    (route_off[noc_lookup_pkg::APB_ADDR_WIDTH-1:2] < 2**noc_lookup_pkg::DEST_WIDTH);
  assign flit_hit  = aligned &
    (flit_off[noc_lookup_pkg::APB_ADDR_WIDTH-1:2] < noc_lookup_pkg::OUTPUTS);
  assign pkt_hit   = aligned &
    (pkt_off[noc_lookup_pkg::APB_ADDR_WIDTH-1:2] < noc_lookup_pkg::OUTPUTS);

  // Word index inside each region
  assign route_idx = route_off[noc_lookup_pkg::DEST_WIDTH+1:2];
  assign flit_idx  = flit_off[noc_lookup_pkg::PORT_IDX_WIDTH+1:2];
  assign pkt_idx   = pkt_off[noc_lookup_pkg::PORT_IDX_WIDTH+1:2];

  // Whole write word must name an existing port
  assign wdata_ok = (apb_req.pwdata < noc_lookup_pkg::OUTPUTS);
  assign route_we = access & apb_req.pwrite & route_hit & wdata_ok;

  ////////////////////
  // Table storage

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**noc_lookup_pkg::DEST_WIDTH; i++) begin
        route_q[i] <= noc_lookup_pkg::PORT_LOCAL;
      end
    end else if (route_we) begin
      route_q[route_idx] <=
        noc_lookup_pkg::out_port_e'(apb_req.pwdata[noc_lookup_pkg::PORT_IDX_WIDTH-1:0]);
    end
  end

  // Header lookup, no delay
  assign lookup_port = route_q[lookup_dest];

  ////////////////////
  // Read mux and response

  always_comb begin
    rd_data = '0;
    if (route_hit) begin
      // Entries read back zero-extended
      rd_data[noc_lookup_pkg::PORT_IDX_WIDTH-1:0] = route_q[route_idx];
    end else if (flit_hit) begin
      rd_data = flit_cnt[flit_idx];
    end else if (pkt_hit) begin
      rd_data = pkt_cnt[pkt_idx];
    end
  end

  assign apb_rsp.prdata = rd_data;
  assign apb_rsp.pready = 1'b1;

  // Writes only land on route entries with a legal port
  // Reads fail only on unmapped addresses
  always_comb begin
    apb_rsp.pslverr = 1'b0;
    if (access) begin
      if (apb_req.pwrite) begin
        apb_rsp.pslverr = ~(route_hit & wdata_ok);
      end else begin
        apb_rsp.pslverr = ~(route_hit | flit_hit | pkt_hit);
      end
    end
  end

endmodule

/* rtl/router_lookup.sv */
////////////////////
// Route lookup stage top, framing, table, slice and counters
////////////////////
module router_lookup (
  input  logic                               clk,
  input  logic                               rst,
  input  noc_lookup_pkg::flit_t              in_flit,
  input  logic                               in_valid,
  output logic                               in_ready,
  output noc_lookup_pkg::flit_t              out_flit,
  output logic [noc_lookup_pkg::OUTPUTS-1:0] out_valid,
  input  logic [noc_lookup_pkg::OUTPUTS-1:0] out_ready,
  input  noc_lookup_pkg::apb_req_t           apb_req,
  output noc_lookup_pkg::apb_rsp_t           apb_rsp
);

  // Header lookup
  logic [noc_lookup_pkg::DEST_WIDTH-1:0] lookup_dest;
  noc_lookup_pkg::out_port_e             lookup_port;

  // Framing to slice
  logic [noc_lookup_pkg::OUTPUTS-1:0]    slice_valid;
  logic                                  slice_ready;

  // Statistics to register block
  logic [noc_lookup_pkg::OUTPUTS-1:0][noc_lookup_pkg::CNT_WIDTH-1:0] flit_cnt;
  logic [noc_lookup_pkg::OUTPUTS-1:0][noc_lookup_pkg::CNT_WIDTH-1:0] pkt_cnt;

  packet_route_fsm i_route_fsm (
    .clk         (clk),
    .rst         (rst),
    .in_flit     (in_flit),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .lookup_dest (lookup_dest),
    .lookup_port (lookup_port),
    .slice_valid (slice_valid),
    .slice_ready (slice_ready)
  );

  route_table_apb i_route_table (
    .clk         (clk),
    .rst         (rst),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .lookup_dest (lookup_dest),
    .lookup_port (lookup_port),
    .flit_cnt    (flit_cnt),
    .pkt_cnt     (pkt_cnt)
  );

  // Flit itself passes unchanged, only valid is steered
  lookup_slice i_slice (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (in_flit),
    .in_valid  (slice_valid),
    .in_ready  (slice_ready),
    .out_flit  (out_flit),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  port_flit_counters i_counters (
    .clk       (clk),
    .rst       (rst),
    .out_flit  (out_flit),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .flit_cnt  (flit_cnt),
    .pkt_cnt   (pkt_cnt)
  );

endmodule

/* run.sh */
#!/bin/sh
# Build the route lookup testbench with Verilator, run it, and check the log

verilator --binary --timing -Wno-fatal --top-module tb_router_lookup -f list.f \
  -o sim_router_lookup > build.log 2>&1 ||
  { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_router_lookup > sim.log 2>&1
cat sim.log

grep -q "^TEST RESULT: PASS$" sim.log && echo "Simulation passed" ||
  { echo "Simulation failed, see sim.log"; exit 1; }

/* tests/tb_router_lookup.sv */
////////////////////
// Testbench for the route lookup stage with random traffic and APB accesses
// Reference model with shadow table, per-output flit queues and counters
////////////////////
module tb_router_lookup;

  localparam int RESET_CYCLES   = 10;
  localparam int TRAFFIC_PKTS   = 200;
  localparam int REWRITE_PKTS   = 100;
  localparam int REWRITES       = 40;
  localparam int MAX_PKT_FLITS  = 4;
  // Longest possible traffic of tests 3, 4 and 5
  localparam int PLANNED_FLITS  = (2 * TRAFFIC_PKTS + REWRITE_PKTS) * MAX_PKT_FLITS;
  // Tests 1, 2, 5 and 6
  localparam int APB_ACCESSES   = 26 + 54 + REWRITES + 10;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 40 * PLANNED_FLITS + 4 * APB_ACCESSES;
  localparam int ENTRIES        = 2**noc_lookup_pkg::DEST_WIDTH;

  logic                               clk;
  logic                               rst;
  noc_lookup_pkg::flit_t              in_flit;
  logic                               in_valid;
  logic                               in_ready;
  noc_lookup_pkg::flit_t              out_flit;
  logic [noc_lookup_pkg::OUTPUTS-1:0] out_valid;
  logic [noc_lookup_pkg::OUTPUTS-1:0] out_ready;
  noc_lookup_pkg::apb_req_t           apb_req;
  noc_lookup_pkg::apb_rsp_t           apb_rsp;

  ////////////////////
  // Model state

  noc_lookup_pkg::out_port_e              shadow_route [ENTRIES];
  // Expected flits per output, in acceptance order
  noc_lookup_pkg::flit_t                  exp_q [noc_lookup_pkg::OUTPUTS][$];
  logic [noc_lookup_pkg::CNT_WIDTH-1:0]   model_flits [noc_lookup_pkg::OUTPUTS];
  logic [noc_lookup_pkg::CNT_WIDTH-1:0]   model_pkts [noc_lookup_pkg::OUTPUTS];
  // Framing as seen at the input
  logic                                   in_head;
  noc_lookup_pkg::out_port_e              pkt_port;

  integer      seed;
  integer      ready_seed;
  logic [31:0] ready_rnd;
  logic        random_ready = 1'b0;
  int          error_count;
  int          test_errors;
  int          tests_passed;
  int          tests_failed;
  int          cycle_count;
  logic [noc_lookup_pkg::DEST_WIDTH-1:0] rw_dest [REWRITES];
  logic [31:0] rw_port [REWRITES];
  int          rw_gap [REWRITES];

  router_lookup i_router_lookup (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (in_flit),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_flit  (out_flit),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Output back-pressure is all ready or random per port
  initial begin
    ready_seed = 32'h847;
    out_ready  = '1;
    forever begin
      @(negedge clk);
      ready_rnd = $random(ready_seed);
      out_ready = random_ready ? ready_rnd[noc_lookup_pkg::OUTPUTS-1:0] : '1;
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Run stopped after %0d cycles, traffic or APB accesses never completed",
             cycle_count);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  ////////////////////
  // Address map helpers

  function automatic logic [7:0] route_addr(input int d);
    return noc_lookup_pkg::ROUTE_BASE + 8'(4 * d);
  endfunction

  function automatic logic [7:0] flit_cnt_addr(input int i);
    return noc_lookup_pkg::FLIT_CNT_BASE + 8'(4 * i);
  endfunction

  function automatic logic [7:0] pkt_cnt_addr(input int i);
    return noc_lookup_pkg::PKT_CNT_BASE + 8'(4 * i);
  endfunction

  // Only legal ports on aligned table addresses are stored
  function automatic logic write_fails(input logic [7:0] addr, input logic [31:0] data);
    return !(addr[1:0] == 2'b00 && addr < route_addr(ENTRIES) &&
             data < noc_lookup_pkg::OUTPUTS);
  endfunction

  function automatic noc_lookup_pkg::apb_rsp_t expect_read(input logic [7:0] addr);
    noc_lookup_pkg::apb_rsp_t r;
    r        = '0;
    r.pready = 1'b1;
    if (addr[1:0] != 2'b00) begin
      r.pslverr = 1'b1;
    end else if (addr < route_addr(ENTRIES)) begin
      r.prdata = 32'(shadow_route[(addr - noc_lookup_pkg::ROUTE_BASE) >> 2]);
    end else if (addr >= flit_cnt_addr(0) && addr < flit_cnt_addr(noc_lookup_pkg::OUTPUTS)) begin
      r.prdata = model_flits[(addr - noc_lookup_pkg::FLIT_CNT_BASE) >> 2];
    end else if (addr >= pkt_cnt_addr(0) && addr < pkt_cnt_addr(noc_lookup_pkg::OUTPUTS)) begin
      r.prdata = model_pkts[(addr - noc_lookup_pkg::PKT_CNT_BASE) >> 2];
    end else begin
      // Unmapped address reads zero
      r.pslverr = 1'b1;
    end
    return r;
  endfunction

  ////////////////////
  // Compare tasks

  task automatic check_flit(input int port, input noc_lookup_pkg::flit_t got);
    noc_lookup_pkg::flit_t exp;
    if (exp_q[port].size() == 0) begin
      $display("Output %0d delivered a flit that was never sent to it or came twice", port);
      error_count++;
    end else begin
      exp = exp_q[port].pop_front();
      if (got !== exp) begin
        $display("[ERROR] out_flit on output %0d: got %h, expected %h", port, got, exp);
        error_count++;
      end
    end
  endtask

  task automatic check_apb_rsp(input logic [7:0] addr, input noc_lookup_pkg::apb_rsp_t got,
                               input noc_lookup_pkg::apb_rsp_t exp, input logic with_data);
    if (got.pready !== exp.pready || got.pslverr !== exp.pslverr) begin
      $display("[ERROR] apb_rsp pready/pslverr at %h: got %h/%h, expected %h/%h",
               addr, got.pready, got.pslverr, exp.pready, exp.pslverr);
      error_count++;
    end
    if (with_data && got.prdata !== exp.prdata) begin
      $display("[ERROR] apb_rsp.prdata at %h: got %h, expected %h",
               addr, got.prdata, exp.prdata);
      error_count++;
    end
  endtask

  task automatic check_port(input int entry, input noc_lookup_pkg::out_port_e got,
                            input noc_lookup_pkg::out_port_e exp);
    if (got !== exp) begin
      $display("[ERROR] route entry %0d: got %h, expected %h", entry, got, exp);
      error_count++;
    end
  endtask

  task automatic check_level(input string name, input logic [noc_lookup_pkg::OUTPUTS-1:0] got,
                             input logic [noc_lookup_pkg::OUTPUTS-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  ////////////////////
  // Monitor and reference model

  always @(posedge clk) begin
    if (!rst) begin
      if (out_valid != '0 && !$onehot(out_valid)) begin
        $display("[ERROR] out_valid: got %h, not one-hot", out_valid);
        error_count++;
      end
      for (int i = 0; i < noc_lookup_pkg::OUTPUTS; i++) begin
        if (out_valid[i] && out_ready[i]) begin
          check_flit(i, out_flit);
        end
      end
      // Header picks the port from the table before any write on this edge
      if (in_valid && in_ready) begin
        if (in_head) begin
          pkt_port = shadow_route[in_flit.data[noc_lookup_pkg::DEST_LSB +:
                                               noc_lookup_pkg::DEST_WIDTH]];
        end
        exp_q[pkt_port].push_back(in_flit);
        // Shadow counters follow the flits sent to each output
        model_flits[pkt_port]++;
        if (in_flit.last) begin
          model_pkts[pkt_port]++;
        end
        in_head = in_flit.last;
      end
      if (apb_req.psel && apb_req.penable && apb_req.pwrite &&
          !write_fails(apb_req.paddr, apb_req.pwdata)) begin
        shadow_route[(apb_req.paddr - noc_lookup_pkg::ROUTE_BASE) >> 2] =
          noc_lookup_pkg::out_port_e'(apb_req.pwdata[noc_lookup_pkg::PORT_IDX_WIDTH-1:0]);
      end
    end
  end

  ////////////////////
  // Stimulus tasks

  // Setup, access, then idle
  task automatic apb_cycle(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                           output noc_lookup_pkg::apb_rsp_t rsp);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    @(posedge clk);
    rsp = apb_rsp;
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    noc_lookup_pkg::apb_rsp_t got;
    noc_lookup_pkg::apb_rsp_t exp;
    exp         = '0;
    exp.pready  = 1'b1;
    exp.pslverr = write_fails(addr, data);
    apb_cycle(1'b1, addr, data, got);
    check_apb_rsp(addr, got, exp, 1'b0);
  endtask

  task automatic read_reg(input logic [7:0] addr);
    noc_lookup_pkg::apb_rsp_t got;
    apb_cycle(1'b0, addr, '0, got);
    check_apb_rsp(addr, got, expect_read(addr), 1'b1);
  endtask

  task automatic read_entry(input int d);
    noc_lookup_pkg::apb_rsp_t got;
    apb_cycle(1'b0, route_addr(d), '0, got);
    check_apb_rsp(route_addr(d), got, expect_read(route_addr(d)), 1'b1);
    check_port(d, noc_lookup_pkg::out_port_e'(got.prdata[noc_lookup_pkg::PORT_IDX_WIDTH-1:0]),
               shadow_route[d]);
  endtask

  // Entered on a falling edge and left on the falling edge after acceptance
  task automatic send_flit(input noc_lookup_pkg::flit_t f);
    logic taken;
    in_flit  = f;
    in_valid = 1'b1;
    do begin
      @(posedge clk);
      taken = in_ready;
      @(negedge clk);
    end while (!taken);
    in_valid = 1'b0;
  endtask

  task automatic send_packets(input int count);
    noc_lookup_pkg::flit_t f;
    int                    len;
    @(negedge clk);
    for (int p = 0; p < count; p++) begin
      len = ({$random(seed)} % MAX_PKT_FLITS) + 1;
      // Destination rides in the header's top bits
      for (int k = 0; k < len; k++) begin
        f.data = $random(seed);
        f.last = (k == len - 1);
        send_flit(f);
      end
      if ($random(seed) & 1) begin
        @(negedge clk);
      end
    end
  endtask

  function automatic int pending();
    int n;
    n = 0;
    for (int i = 0; i < noc_lookup_pkg::OUTPUTS; i++) begin
      n += exp_q[i].size();
    end
    return n;
  endfunction

  task automatic wait_drain();
    while (pending() != 0 || out_valid != '0) begin
      @(negedge clk);
    end
  endtask

  task automatic end_test(input int num, input string name);
    if (error_count == test_errors) begin
      $display("Test %0d %s: passed", num, name);
      tests_passed++;
    end else begin
      $display("Test %0d %s: failed with %0d errors", num, name, error_count - test_errors);
      tests_failed++;
    end
    test_errors = error_count;
  endtask

  ////////////////////
  // Test sequence

  initial begin
    seed         = 32'h847;
    rst          = 1'b1;
    in_flit      = '0;
    in_valid     = 1'b0;
    apb_req      = '0;
    error_count  = 0;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    in_head      = 1'b1;
    pkt_port     = noc_lookup_pkg::PORT_LOCAL;
    for (int d = 0; d < ENTRIES; d++) begin
      shadow_route[d] = noc_lookup_pkg::PORT_LOCAL;
    end
    for (int i = 0; i < noc_lookup_pkg::OUTPUTS; i++) begin
      model_flits[i] = '0;
      model_pkts[i]  = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Idle outputs, default table, cleared counters
    check_level("out_valid", out_valid, '0);
    check_level("in_ready", in_ready, 1);
    for (int d = 0; d < ENTRIES; d++) begin
      read_entry(d);
    end
    for (int i = 0; i < noc_lookup_pkg::OUTPUTS; i++) begin
      read_reg(flit_cnt_addr(i));
      read_reg(pkt_cnt_addr(i));
    end
    end_test(1, "reset state");

    for (int d = 0; d < ENTRIES; d++) begin
      write_reg(route_addr(d), {$random(seed)} % noc_lookup_pkg::OUTPUTS);
    end
    for (int d = 0; d < ENTRIES; d++) begin
      read_entry(d);
    end
    // Bad port index, wide word, counter writes, unmapped reads
    write_reg(route_addr(3), noc_lookup_pkg::OUTPUTS + ({$random(seed)} % 3));
    write_reg(route_addr(9), 32'h0000_0101);
    write_reg(flit_cnt_addr(1), 32'h1);
    write_reg(pkt_cnt_addr(0), 32'h0);
    read_reg(8'h80);
    read_reg(8'h54);
    for (int d = 0; d < ENTRIES; d++) begin
      read_entry(d);
    end
    end_test(2, "table access and errors");

    random_ready = 1'b0;
    send_packets(TRAFFIC_PKTS);
    wait_drain();
    end_test(3, "traffic, outputs ready");

    random_ready = 1'b1;
    send_packets(TRAFFIC_PKTS);
    wait_drain();
    end_test(4, "traffic, random back-pressure");

    for (int w = 0; w < REWRITES; w++) begin
      rw_dest[w] = $random(seed);
      rw_port[w] = {$random(seed)} % noc_lookup_pkg::OUTPUTS;
      rw_gap[w]  = {$random(seed)} % 16;
    end
    // Table rewrites race the packets in flight
    fork
      send_packets(REWRITE_PKTS);
      for (int w = 0; w < REWRITES; w++) begin
        repeat (rw_gap[w]) @(negedge clk);
        write_reg(route_addr(rw_dest[w]), rw_port[w]);
      end
    join
    wait_drain();
    end_test(5, "rewrites during traffic");

    random_ready = 1'b0;
    for (int i = 0; i < noc_lookup_pkg::OUTPUTS; i++) begin
      read_reg(flit_cnt_addr(i));
      read_reg(pkt_cnt_addr(i));
    end
    end_test(6, "flit and packet counters");

    $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
             error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
